// ==== dv/ctl_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctl_sva import ctl_pkg::*; (
	input logic         __clk,
	input logic         arst_n,
	input strob_state_e state,
	input logic         got,
	input logic         strob1,
	input logic         strob1b,
	input logic         strob2,
	input logic         strob2b,
	input logic         seq_mreq,
	input logic         seq_mack,
	input logic         pnl_req,
	input logic         pnl_ack,
	input logic         mem_en
);

	// Failed assertions so far
	int fail_count = 0;

	// Exactly one strobe phase at any time
	a_strob_onehot: assert property (@(posedge __clk) disable iff (!arst_n)
		$onehot({got, strob1, strob1b, strob2, strob2b}))
		else begin
			$error("strobe phases not one-hot");
			fail_count++;
		end

	// Leaving GOT always starts with a STROB1 front
	a_got_exit: assert property (@(posedge __clk) disable iff (!arst_n)
		(got ##1 !got) |-> strob1)
		else begin
			$error("GOT left without STROB1");
			fail_count++;
		end

	// STROB2 back phase ends only in GOT
	a_st2b_exit: assert property (@(posedge __clk) disable iff (!arst_n)
		(state == ST2B) |=> (state == ST2B) || (state == GOT))
		else begin
			$error("ST2B left to a state other than GOT");
			fail_count++;
		end

	// Four-phase rules, req drops only after ack
	a_seq_req_fall: assert property (@(posedge __clk) disable iff (!arst_n)
		$fell(seq_mreq) |-> $past(seq_mack))
		else begin
			$error("seq_mreq dropped before seq_mack");
			fail_count++;
		end

	a_pnl_ack_fall: assert property (@(posedge __clk) disable iff (!arst_n)
		$fell(pnl_ack) |-> !pnl_req)
		else begin
			$error("pnl_ack dropped while pnl_req high");
			fail_count++;
		end

	// Single-cycle access, acked on the next cycle
	a_mem_en_ack: assert property (@(posedge __clk) disable iff (!arst_n)
		mem_en |=> !mem_en && (seq_mack || pnl_ack))
		else begin
			$error("mem_en not a single cycle followed by an ack");
			fail_count++;
		end

endmodule

// Arbiter side tied idle here
bind strob_gen ctl_sva sva_strob_i (
	.__clk    (__clk),
	.arst_n   (arst_n),
	.state    (state),
	.got      (got),
	.strob1   (strob1),
	.strob1b  (strob1b),
	.strob2   (strob2),
	.strob2b  (strob2b),
	.seq_mreq (1'b0),
	.seq_mack (1'b0),
	.pnl_req  (1'b0),
	.pnl_ack  (1'b0),
	.mem_en   (1'b0)
);

// Strobe side parked in GOT here
bind mem_arbiter ctl_sva sva_arb_i (
	.__clk    (__clk),
	.arst_n   (arst_n),
	.state    (GOT),
	.got      (1'b1),
	.strob1   (1'b0),
	.strob1b  (1'b0),
	.strob2   (1'b0),
	.strob2b  (1'b0),
	.seq_mreq (seq_mreq),
	.seq_mack (seq_mack),
	.pnl_req  (pnl_req),
	.pnl_ack  (pnl_ack),
	.mem_en   (mem_en)
);

`default_nettype wire

// ==== dv/ctl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ctl_defines.svh"

module ctl_tb import ctl_pkg::*; ();

	// Test sizes
	localparam int N_ADDS = 6;
	localparam int N_RAND = 40;
	localparam int WIN = 16;
	localparam int HOLD = 12;
	localparam addr_t SEQ_BASE = 8'h80;
	localparam addr_t PNL_BASE = 8'h90;
	// Every command and panel access of all tests
	localparam int N_XFERS = 4 + (2 * N_ADDS + 3) + 2 + 2 * WIN + 2 * N_RAND;
	localparam int WATCHDOG_CYCLES = 200 * N_XFERS + 8 + HOLD;

	logic __clk;
	logic arst_n;
	logic cmd_req;
	cmd_t cmd;
	logic cmd_ack;
	word_t acc;
	logic pnl_req;
	mem_req_t pnl;
	logic pnl_ack;
	word_t pnl_rdata;
	logic mode;
	logic step;
	logic oken;
	logic ok;
	logic got;
	logic strob1;
	logic strob2;

	// Reference model
	word_t ref_mem [`CTL_MEM_DEPTH];
	word_t ref_acc;
	// Strobes seen during the current command
	logic saw_s1;
	logic saw_s2;

	ctl_top ctl_top_i (
		.__clk     (__clk),
		.arst_n    (arst_n),
		.cmd_req   (cmd_req),
		.cmd       (cmd),
		.cmd_ack   (cmd_ack),
		.acc       (acc),
		.pnl_req   (pnl_req),
		.pnl       (pnl),
		.pnl_ack   (pnl_ack),
		.pnl_rdata (pnl_rdata),
		.mode      (mode),
		.step      (step),
		.oken      (oken),
		.ok        (ok),
		.got       (got),
		.strob1    (strob1),
		.strob2    (strob2)
	);

	initial __clk = 1'b0;
	always #4 __clk = ~__clk;

	task automatic abort_run();
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %s: got %h, expected %h", name, actual, expected);
			abort_run();
		end
	endtask

	// Whole run budget
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge __clk);
		$display("Timeout: handshakes did not finish within %0d cycles", WATCHDOG_CYCLES);
		abort_run();
	end

	// Bound assertions on the strobe generator and the arbiter
	initial begin
		wait (ctl_top_i.strob_gen_i.sva_strob_i.fail_count != 0 ||
			ctl_top_i.mem_arbiter_i.sva_arb_i.fail_count != 0);
		$display("A bound assertion on the strobes or handshakes failed");
		abort_run();
	end

	// One clock, remember which strobes showed
	task automatic sample_strobes();
		@(posedge __clk);
		if (strob1) begin
			saw_s1 = 1'b1;
		end
		if (strob2) begin
			saw_s2 = 1'b1;
		end
	endtask

	task automatic start_cmd(input cmd_op_e op, input addr_t a);
		@(posedge __clk);
		cmd_req <= 1'b1;
		cmd <= '{op: op, addr: a};
		saw_s1 = 1'b0;
		saw_s2 = 1'b0;
	endtask

	// Wait for ack, predict acc, then close the handshake
	task automatic finish_cmd(input cmd_op_e op, input addr_t a);
		do sample_strobes(); while (!cmd_ack);
		if (op == LOAD) begin
			ref_acc = ref_mem[a];
		end else if (op == ADD) begin
			ref_acc = ref_acc + ref_mem[a];
		end else if (op == STORE) begin
			ref_mem[a] = ref_acc;
		end
		check("acc", acc, ref_acc);
		check("strob1 seen", saw_s1, 1'b1);
		// Only NOP runs without STROB2
		check("strob2 seen", saw_s2, op != NOP);
		cmd_req <= 1'b0;
		do @(posedge __clk); while (cmd_ack);
	endtask

	task automatic run_cmd(input cmd_op_e op, input addr_t a);
		start_cmd(op, a);
		finish_cmd(op, a);
	endtask

	// Panel read or write, full four-phase cycle
	task automatic panel_access(input logic we, input addr_t a, input word_t d);
		@(posedge __clk);
		pnl_req <= 1'b1;
		pnl <= '{we: we, addr: a, wdata: d};
		do @(posedge __clk); while (!pnl_ack);
		if (we) begin
			ref_mem[a] = d;
		end else begin
			check("pnl_rdata", pnl_rdata, ref_mem[a]);
		end
		pnl_req <= 1'b0;
		do @(posedge __clk); while (pnl_ack);
	endtask

	task automatic reset_values();
		@(posedge __clk);
		check("got", got, 1'b1);
		check("strob1", strob1, 1'b0);
		check("strob2", strob2, 1'b0);
		check("cmd_ack", cmd_ack, 1'b0);
		check("pnl_ack", pnl_ack, 1'b0);
		check("acc", acc, 16'h0000);
	endtask

	// Panel write seen by LOAD, STORE seen by panel read
	task automatic store_and_read();
		panel_access(1'b1, 8'h10, word_t'($urandom));
		run_cmd(LOAD, 8'h10);
		run_cmd(STORE, 8'h20);
		panel_access(1'b0, 8'h20, '0);
	endtask

	task automatic accumulate();
		addr_t base;
		word_t sum;
		int i;
		base = 8'h40;
		for (i = 0; i <= N_ADDS; i++) begin
			panel_access(1'b1, addr_t'(base + i), word_t'($urandom));
		end
		run_cmd(LOAD, base);
		for (i = 1; i <= N_ADDS; i++) begin
			run_cmd(ADD, addr_t'(base + i));
		end
		// Sum of the written words, wraps at 16 bits
		sum = '0;
		for (i = 0; i <= N_ADDS; i++) begin
			sum = sum + ref_mem[addr_t'(base + i)];
		end
		check("acc sum", acc, sum);
		run_cmd(NOP, 8'h00);
	endtask

	// LOAD held in STROB1 until the step key
	task automatic step_mode();
		int i;
		panel_access(1'b1, 8'h60, word_t'($urandom));
		mode <= 1'b1;
		start_cmd(LOAD, 8'h60);
		do sample_strobes(); while (!strob1);
		for (i = 0; i < HOLD; i++) begin
			sample_strobes();
			check("strob1 held", strob1, 1'b1);
			check("cmd_ack held", cmd_ack, 1'b0);
		end
		step <= 1'b1;
		@(posedge __clk);
		step <= 1'b0;
		finish_cmd(LOAD, 8'h60);
		mode <= 1'b0;
	endtask

	// Sequencer and panel work on separate windows so order between them does not matter
	task automatic contention();
		cmd_op_e ops [N_RAND];
		addr_t seq_addr [N_RAND];
		logic pnl_we [N_RAND];
		addr_t pnl_addr [N_RAND];
		word_t pnl_data [N_RAND];
		int i;
		// Both windows start with known words
		for (i = 0; i < 2 * WIN; i++) begin
			panel_access(1'b1, addr_t'(SEQ_BASE + i), word_t'($urandom));
		end
		for (i = 0; i < N_RAND; i++) begin
			ops[i] = cmd_op_e'($urandom_range(3, 0));
			seq_addr[i] = addr_t'(SEQ_BASE + $urandom_range(WIN - 1, 0));
			pnl_we[i] = $urandom_range(1, 0);
			pnl_addr[i] = addr_t'(PNL_BASE + $urandom_range(WIN - 1, 0));
			pnl_data[i] = word_t'($urandom);
		end
		fork
			begin
				for (int k = 0; k < N_RAND; k++) begin
					run_cmd(ops[k], seq_addr[k]);
				end
			end
			begin
				for (int k = 0; k < N_RAND; k++) begin
					panel_access(pnl_we[k], pnl_addr[k], pnl_data[k]);
				end
			end
		join
	endtask

	initial begin
		void'($urandom(32'hc3c62aec));
		arst_n = 1'b0;
		cmd_req = 1'b0;
		cmd = '0;
		pnl_req = 1'b0;
		pnl = '0;
		mode = 1'b0;
		step = 1'b0;
		oken = 1'b1;
		ok = 1'b1;
		ref_acc = '0;
		repeat (8) @(posedge __clk);
		arst_n <= 1'b1;
		reset_values();
		store_and_read();
		accumulate();
		step_mode();
		contention();
		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
logic/ctl_pkg.sv
logic/strob_gen.sv
logic/cycle_seq.sv
logic/mem_arbiter.sv
logic/mem_array.sv
logic/ctl_top.sv
dv/ctl_sva.sv
dv/ctl_tb.sv

// ==== include/ctl_defines.svh ====
`ifndef CTL_DEFINES_SVH
`define CTL_DEFINES_SVH

// Machine widths
// The control core is built around a 16-bit word and a small
// core store, so these are fixed rather than tunable

// Data word, accumulator and memory word
`define CTL_WORD_W 16

// Core store address
`define CTL_ADDR_W 8

// Number of words in the core store
// must stay equal to 2**CTL_ADDR_W
`define CTL_MEM_DEPTH 256

// Width of a command opcode
`define CTL_OP_W 2

`endif

// ==== logic/ctl_pkg.sv ====
`default_nettype none

`include "ctl_defines.svh"

package ctl_pkg;

	// Plain vectors with a meaning
	typedef logic [`CTL_WORD_W-1:0] word_t;
	typedef logic [`CTL_ADDR_W-1:0] addr_t;

	// Command operations
	typedef enum logic [`CTL_OP_W-1:0] {
		NOP   = 2'd0,
		LOAD  = 2'd1,
		STORE = 2'd2,
		ADD   = 2'd3
	} cmd_op_e;

	// One command from the outside, 10 bits
	typedef struct packed {
		cmd_op_e op;
		addr_t   addr;
	} cmd_t;

	// One memory request, 25 bits
	typedef struct packed {
		logic  we;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	// Strobe generator phases, same codes as the old strobe logic
	typedef enum logic [2:0] {
		GOT   = 3'd0,
		ST1   = 3'd1,
		ST1B  = 3'd2,
		ST12  = 3'd3,
		ST12B = 3'd4,
		ST2   = 3'd5,
		ST2B  = 3'd6
	} strob_state_e;

	// Cycle sequencer
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,
		MEM  = 2'd2,
		DONE = 2'd3
	} seq_state_e;

endpackage

`default_nettype wire

// ==== logic/ctl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctl_top import ctl_pkg::*; (
	input  logic     __clk,
	input  logic     arst_n,
	input  logic     cmd_req,
	input  cmd_t     cmd,
	output logic     cmd_ack,
	output word_t    acc,
	input  logic     pnl_req,
	input  mem_req_t pnl,
	output logic     pnl_ack,
	output word_t    pnl_rdata,
	input  logic     mode,
	input  logic     step,
	input  logic     oken,
	input  logic     ok,
	output logic     got,
	output logic     strob1,
	output logic     strob2
);

	// Strobe link
	logic ss11;
	logic ss12;
	logic ss13;
	logic ss14;
	logic ss15;
	logic zw;

	// Sequencer memory port
	logic seq_mreq;
	logic seq_mack;
	mem_req_t seq_req;

	// Memory side
	logic mem_en;
	mem_req_t mem_req;
	word_t mem_rdata;
	// Read data shared by sequencer and panel
	word_t rdata;

	assign pnl_rdata = rdata;

	cycle_seq cycle_seq_i (
		.__clk    (__clk),
		.arst_n   (arst_n),
		.cmd_req  (cmd_req),
		.cmd      (cmd),
		.cmd_ack  (cmd_ack),
		.acc      (acc),
		.ss11     (ss11),
		.ss12     (ss12),
		.ss13     (ss13),
		.ss14     (ss14),
		.ss15     (ss15),
		.zw       (zw),
		.got      (got),
		.strob1   (strob1),
		.strob2   (strob2),
		.seq_mreq (seq_mreq),
		.seq_req  (seq_req),
		.seq_mack (seq_mack),
		.rdata    (rdata)
	);

	// Back phases are only used inside the strobe generator
	strob_gen strob_gen_i (
		.__clk   (__clk),
		.arst_n  (arst_n),
		.ss11    (ss11),
		.ss12    (ss12),
		.ss13    (ss13),
		.ss14    (ss14),
		.ss15    (ss15),
		.ok      (ok),
		.zw      (zw),
		.oken    (oken),
		.mode    (mode),
		.step    (step),
		.got     (got),
		.strob1  (strob1),
		.strob1b (),
		.strob2  (strob2),
		.strob2b ()
	);

	mem_arbiter mem_arbiter_i (
		.__clk     (__clk),
		.arst_n    (arst_n),
		.seq_mreq  (seq_mreq),
		.pnl_req   (pnl_req),
		.seq_req   (seq_req),
		.pnl       (pnl),
		.seq_mack  (seq_mack),
		.pnl_ack   (pnl_ack),
		.mem_en    (mem_en),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata),
		.rdata     (rdata)
	);

	mem_array mem_array_i (
		.__clk     (__clk),
		.mem_en    (mem_en),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== logic/cycle_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module cycle_seq import ctl_pkg::*; (
	input  logic     __clk,
	input  logic     arst_n,
	input  logic     cmd_req,
	input  cmd_t     cmd,
	output logic     cmd_ack,
	output word_t    acc,
	output logic     ss11,
	output logic     ss12,
	output logic     ss13,
	output logic     ss14,
	output logic     ss15,
	output logic     zw,
	input  logic     got,
	input  logic     strob1,
	input  logic     strob2,
	output logic     seq_mreq,
	output mem_req_t seq_req,
	input  logic     seq_mack,
	input  word_t    rdata
);

	seq_state_e state;

	// Strobe-state selector, bit 0 is ss11 ... bit 4 is ss15
	logic [4:0] sel;
	// STROB2 has been seen for the current command
	logic st2_seen;
	logic is_nop;

	assign {ss15, ss14, ss13, ss12, ss11} = sel;
	assign is_nop = cmd.op == NOP;

	// Transfer pending from request up to the end of the ack
	assign zw = seq_mreq | seq_mack;

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			sel <= '0;
			st2_seen <= 1'b0;
			seq_mreq <= 1'b0;
			cmd_ack <= 1'b0;
			acc <= '0;
		end else begin
			case (state)
				// cmd stays stable until we ack, so it is used directly
				IDLE: begin
					if (cmd_req) begin
						// NOP needs STROB1 only (ss13), the rest run STROB1 and STROB2 (ss11)
						sel <= is_nop ? 5'b00100 : 5'b00001;
						st2_seen <= 1'b0;
						state <= RUN;
					end
				end
				// Strobe sequence has left GOT once STROB1 shows
				RUN: begin
					if (strob1) begin
						sel <= '0;
						seq_mreq <= !is_nop;
						state <= MEM;
					end
				end
				MEM: begin
					if (strob2) begin
						st2_seen <= 1'b1;
					end
					// First ack cycle, read word is valid now
					if (seq_mreq && seq_mack) begin
						seq_mreq <= 1'b0;
						if (cmd.op == LOAD) begin
							acc <= rdata;
						end else if (cmd.op == ADD) begin
							acc <= acc + rdata;
						end
					end
					// Back in GOT with the memory handshake closed
					if (got && !zw && (st2_seen || is_nop)) begin
						cmd_ack <= 1'b1;
						state <= DONE;
					end
				end
				DONE: begin
					if (!cmd_req) begin
						cmd_ack <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Request payload, taken at the STROB1 front
	// STORE writes the accumulator
	always_ff @(posedge __clk) begin
		if (state == RUN && strob1) begin
			seq_req.we <= cmd.op == STORE;
			seq_req.addr <= cmd.addr;
			seq_req.wdata <= acc;
		end
	end

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import ctl_pkg::*; (
	input  logic     __clk,
	input  logic     arst_n,
	input  logic     seq_mreq,
	input  logic     pnl_req,
	input  mem_req_t seq_req,
	input  mem_req_t pnl,
	output logic     seq_mack,
	output logic     pnl_ack,
	output logic     mem_en,
	output mem_req_t mem_req,
	input  word_t    mem_rdata,
	output word_t    rdata
);

	// Panel holds the current grant, or won the last one
	logic gnt_pnl;

	logic busy;
	logic seq_want;
	logic pnl_want;
	logic pick_pnl;
	logic grant;

	// One access at a time, from grant until its ack has dropped
	assign busy = mem_en | seq_mack | pnl_ack;
	// A port with its ack still up has no new request
	assign seq_want = seq_mreq & ~seq_mack;
	assign pnl_want = pnl_req & ~pnl_ack;
	// Round robin, panel wins a tie only if the sequencer won last
	assign pick_pnl = pnl_want & (~seq_want | ~gnt_pnl);
	assign grant = ~busy & (seq_want | pnl_want);

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_en <= 1'b0;
			gnt_pnl <= 1'b0;
			seq_mack <= 1'b0;
			pnl_ack <= 1'b0;
		end else begin
			mem_en <= grant;
			if (grant) begin
				gnt_pnl <= pick_pnl;
			end
			// ack rises a cycle after mem_en and stays until req falls
			if (mem_en && !gnt_pnl) begin
				seq_mack <= 1'b1;
			end else if (!seq_mreq) begin
				seq_mack <= 1'b0;
			end
			if (mem_en && gnt_pnl) begin
				pnl_ack <= 1'b1;
			end else if (!pnl_req) begin
				pnl_ack <= 1'b0;
			end
		end
	end

	always_ff @(posedge __clk) begin
		if (grant) begin
			mem_req <= pick_pnl ? pnl : seq_req;
		end
	end

	// Shared read bus
	// holds through the whole ack since nothing new is granted meanwhile
	assign rdata = mem_rdata;

endmodule

`default_nettype wire

// ==== logic/mem_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ctl_defines.svh"

module mem_array import ctl_pkg::*; (
	input  logic     __clk,
	input  logic     mem_en,
	input  mem_req_t mem_req,
	output word_t    mem_rdata
);

	// Core store
	word_t mem [`CTL_MEM_DEPTH];

	// One access per mem_en
	// a write also returns the old word on the read port
	always_ff @(posedge __clk) begin
		if (mem_en) begin
			if (mem_req.we) begin
				mem[mem_req.addr] <= mem_req.wdata;
			end
			mem_rdata <= mem[mem_req.addr];
		end
	end

endmodule

`default_nettype wire

// ==== logic/strob_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module strob_gen import ctl_pkg::*; (
	input  logic __clk,
	input  logic arst_n,
	input  logic ss11,
	input  logic ss12,
	input  logic ss13,
	input  logic ss14,
	input  logic ss15,
	input  logic ok,
	input  logic zw,
	input  logic oken,
	input  logic mode,
	input  logic step,
	output logic got,
	output logic strob1,
	output logic strob1b,
	output logic strob2,
	output logic strob2b
);

	strob_state_e state;

	// Step key history and the mode/step hold flop
	logic step_q;
	logic step_hold;

	logic e_s12;
	logic e_s1;
	logic holdoff;
	logic step_edge;
	logic step_go;
	logic front1;
	logic back1;

	// STROB1 followed by STROB2
	assign e_s12 = ss11 | (ss12 & ok);
	// STROB1 alone
	assign e_s1 = (ss13 & ok) | ss14 | ss15;

	// Memory transfer still pending, stay in the back phase
	assign holdoff = zw & oken;

	// Rising edge of the step key
	assign step_edge = step & ~step_q;
	// Back phase of STROB1 may move on
	assign step_go = ~step_hold | step_edge;

	assign front1 = (state == ST1) | (state == ST12);
	assign back1 = (state == ST1B) | (state == ST12B);

	// Hold is armed by any STROB1 front while mode is set
	// mode low keeps it cleared, so step does nothing then
	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			step_q <= 1'b0;
			step_hold <= 1'b0;
		end else begin
			step_q <= step;
			if (!mode) begin
				step_hold <= 1'b0;
			end else if (front1) begin
				step_hold <= 1'b1;
			end else if (step_edge) begin
				step_hold <= 1'b0;
			end
		end
	end

	always_ff @(posedge __clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= GOT;
		end else begin
			case (state)
				// Wait for a selector, STROB2 pattern wins
				GOT: begin
					if (e_s12) begin
						state <= ST12;
					end else if (e_s1) begin
						state <= ST1;
					end
				end
				ST1: state <= ST1B;
				// Lonely STROB1 goes back to GOT, unless held or transfer pending
				ST1B: begin
					if (step_go && !holdoff) begin
						state <= GOT;
					end
				end
				ST12: state <= ST12B;
				// No holdoff here, STROB2 still to come
				ST12B: begin
					if (step_go) begin
						state <= ST2;
					end
				end
				ST2: state <= ST2B;
				ST2B: begin
					if (!holdoff) begin
						state <= GOT;
					end
				end
				default: state <= GOT;
			endcase
		end
	end

	// Strobe decode
	// while held by mode/step STROB1 stays up instead of the back phase
	assign got = state == GOT;
	assign strob1 = front1 | (back1 & step_hold);
	assign strob1b = back1 & ~step_hold;
	assign strob2 = state == ST2;
	assign strob2b = state == ST2B;

endmodule

`default_nettype wire
